/* hw/robotDrivePkg.sv */
package robotDrivePkg;

	////////////////////////////////////////////////////////////
	// Steering command from the line sensors
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		HEAD_PROCEED = 2'b00,
		HEAD_LEFT    = 2'b01,
		HEAD_RIGHT   = 2'b10,
		HEAD_STOP    = 2'b11
	} heading_t;

	typedef enum logic [1:0] {
		SHARP_FULL   = 2'b00,
		SHARP_VEER   = 2'b01,
		SHARP_HARD   = 2'b10,
		SHARP_NINETY = 2'b11
	} sharpness_t;

	typedef struct packed {
		heading_t   heading;
		sharpness_t sharpness;
	} steerCmd_t;

	// One bit per PWM channel, current level
	typedef struct packed {
		logic full;
		logic veer;
		logic hard;
		logic ninety;
		logic ninetyFast;
	} speedSet_t;

	// H-bridge enables and direction pins
	typedef struct packed {
		logic       enA;
		logic       enB;
		logic [3:0] bridgeIn;
	} motorCmd_t;

	////////////////////////////////////////////////////////////
	// Junction command and drive state
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		TONE_STRAIGHT = 3'b000,
		TONE_LEFT     = 3'b001,
		TONE_RIGHT    = 3'b010,
		TONE_BACK     = 3'b011,
		TONE_STOP     = 3'b100
	} toneDir_t;

	typedef enum logic [1:0] {
		ST_DRIVE     = 2'b00,
		ST_COLLISION = 2'b10,
		ST_JUNCTION  = 2'b11
	} driveState_t;

	// Forward pin patterns, reverse is the bit inverse
	localparam logic [3:0] BRIDGE_STRAIGHT = 4'b0110;
	localparam logic [3:0] BRIDGE_LEFT     = 4'b0101;
	localparam logic [3:0] BRIDGE_RIGHT    = 4'b1010;
	localparam logic [3:0] BRIDGE_STOP     = 4'b0000;

endpackage

/* hw/pwmChannel.sv */
`timescale 1ns/1ps

module pwmChannel #(
	parameter int unsigned PWM_PERIOD = 625000,
	parameter int unsigned DUTY       = 168750
) (
	input  logic clk,
	input  logic rst,
	output logic level
);

	localparam int CW = (PWM_PERIOD > 1) ? $clog2(PWM_PERIOD) : 1;

	logic [CW-1:0] count;

	// Free-running period counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (count == CW'(PWM_PERIOD - 1)) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// High for DUTY counts of every period
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			level <= 1'b0;
		end else begin
			level <= (32'(count) < DUTY);
		end
	end

endmodule

/* hw/steeringDecoder.sv */
`timescale 1ns/1ps

module steeringDecoder import robotDrivePkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  steerCmd_t  steerSel,
	input  logic       halt,
	input  logic       invert,
	input  speedSet_t  speeds,
	output motorCmd_t  motor
);

	logic       innerEn;
	logic       outerEn;
	logic       turnPins;
	logic [3:0] fwdPattern;
	motorCmd_t  nextMotor;

	////////////////////////////////////////////////////////////
	// Speed table, inner and outer wheel by sharpness
	////////////////////////////////////////////////////////////

	always_comb begin
		innerEn  = speeds.full;
		outerEn  = speeds.full;
		turnPins = 1'b0;
		case (steerSel.sharpness)
			SHARP_VEER: begin
				innerEn = speeds.veer;
				outerEn = speeds.full;
			end
			SHARP_HARD: begin
				innerEn  = speeds.veer;
				outerEn  = speeds.hard;
				turnPins = 1'b1;
			end
			SHARP_NINETY: begin
				innerEn  = speeds.ninety;
				outerEn  = speeds.ninetyFast;
				turnPins = 1'b1;
			end
			default: begin
				innerEn = speeds.full;
				outerEn = speeds.full;
			end
		endcase
	end

	// Side A is the inner wheel on a left turn
	always_comb begin
		nextMotor = '0;
		fwdPattern = BRIDGE_STOP;
		case (steerSel.heading)
			HEAD_PROCEED: begin
				nextMotor.enA = speeds.full;
				nextMotor.enB = speeds.full;
				fwdPattern    = BRIDGE_STRAIGHT;
			end
			HEAD_LEFT: begin
				nextMotor.enA = innerEn;
				nextMotor.enB = outerEn;
				fwdPattern    = turnPins ? BRIDGE_LEFT : BRIDGE_STRAIGHT;
			end
			HEAD_RIGHT: begin
				nextMotor.enA = outerEn;
				nextMotor.enB = innerEn;
				fwdPattern    = turnPins ? BRIDGE_RIGHT : BRIDGE_STRAIGHT;
			end
			default: begin
				fwdPattern = BRIDGE_STOP;
			end
		endcase
		// Running in reverse flips every driven pin
		if (invert && fwdPattern != BRIDGE_STOP) begin
			nextMotor.bridgeIn = ~fwdPattern;
		end else begin
			nextMotor.bridgeIn = fwdPattern;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			motor <= '0;
		end else if (halt) begin
			// Pins keep their value, wheels stop
			motor.enA <= 1'b0;
			motor.enB <= 1'b0;
		end else begin
			motor <= nextMotor;
		end
	end

endmodule

/* hw/junctionSequencer.sv */
`timescale 1ns/1ps

module junctionSequencer import robotDrivePkg::*; #(
	parameter int unsigned MANEUVER_CYCLES = 50_000_000
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       atJunction,
	input  logic       toneReq,
	input  toneDir_t   toneDir,
	output logic       toneAck,
	output steerCmd_t  maneuverSteer,
	output logic       maneuverInvert,
	output logic       maneuverDone,
	output logic       exitReverse,
	output logic [4:0] junctionLeds
);

	localparam int CW = (MANEUVER_CYCLES > 1) ? $clog2(MANEUVER_CYCLES) : 1;

	toneDir_t      cmd;
	logic          running;
	logic [CW-1:0] count;
	logic          accept;
	logic [4:0]    cmdLeds;

	// New request only while parked at a junction with no timer active
	assign accept = toneReq && !toneAck && atJunction && !running;

	assign maneuverDone = running && (count == CW'(MANEUVER_CYCLES - 1));
	assign exitReverse  = maneuverDone && (cmd == TONE_BACK);

	always_comb begin
		case (toneDir)
			TONE_STOP:     cmdLeds = 5'b00001;
			TONE_STRAIGHT: cmdLeds = 5'b00010;
			TONE_LEFT:     cmdLeds = 5'b00100;
			TONE_RIGHT:    cmdLeds = 5'b01000;
			TONE_BACK:     cmdLeds = 5'b10000;
			default:       cmdLeds = 5'b00000;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Handshake, command latch and maneuver timer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			toneAck      <= 1'b0;
			cmd          <= TONE_STOP;
			running      <= 1'b0;
			count        <= '0;
			junctionLeds <= '0;
		end else begin
			if (accept) begin
				toneAck      <= 1'b1;
				cmd          <= toneDir;
				junctionLeds <= cmdLeds;
				count        <= '0;
				// Stop has no timer and waits for the next command
				running      <= (toneDir != TONE_STOP);
			end else if (toneAck && !toneReq) begin
				toneAck <= 1'b0;
			end

			if (maneuverDone) begin
				running      <= 1'b0;
				junctionLeds <= '0;
			end else if (running) begin
				count <= count + 1'b1;
			end
		end
	end

	// Steering during the maneuver, stopped otherwise
	always_comb begin
		maneuverSteer  = '{heading: HEAD_STOP, sharpness: SHARP_FULL};
		maneuverInvert = 1'b0;
		if (running) begin
			case (cmd)
				TONE_STRAIGHT: maneuverSteer = '{heading: HEAD_PROCEED, sharpness: SHARP_FULL};
				TONE_LEFT:     maneuverSteer = '{heading: HEAD_LEFT, sharpness: SHARP_NINETY};
				TONE_RIGHT:    maneuverSteer = '{heading: HEAD_RIGHT, sharpness: SHARP_NINETY};
				TONE_BACK: begin
					maneuverSteer  = '{heading: HEAD_PROCEED, sharpness: SHARP_FULL};
					maneuverInvert = 1'b1;
				end
				default:       maneuverSteer = '{heading: HEAD_STOP, sharpness: SHARP_FULL};
			endcase
		end
	end

endmodule

/* hw/driveController.sv */
`timescale 1ns/1ps

module driveController import robotDrivePkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  steerCmd_t steer,
	input  logic      obstacle,
	input  steerCmd_t maneuverSteer,
	input  logic      maneuverInvert,
	input  logic      maneuverDone,
	input  logic      exitReverse,
	output logic      atJunction,
	output steerCmd_t steerSel,
	output logic      halt,
	output logic      invert
);

	driveState_t state;
	logic        reverseFlag;

	assign atJunction = (state == ST_JUNCTION);
	assign halt       = (state == ST_COLLISION);

	////////////////////////////////////////////////////////////
	// Drive FSM with registered steering source
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= ST_DRIVE;
			reverseFlag <= 1'b0;
			steerSel    <= '{heading: HEAD_STOP, sharpness: SHARP_FULL};
			invert      <= 1'b0;
		end else begin
			case (state)
				ST_DRIVE: begin
					steerSel <= steer;
					invert   <= reverseFlag;
					// Obstacle wins over a junction mark
					if (obstacle) begin
						state <= ST_COLLISION;
					end else if (steer.heading == HEAD_STOP) begin
						state <= ST_JUNCTION;
					end
				end
				ST_COLLISION: begin
					steerSel <= steer;
					invert   <= reverseFlag;
					if (!obstacle) begin
						state <= ST_DRIVE;
					end
				end
				ST_JUNCTION: begin
					steerSel <= maneuverSteer;
					invert   <= maneuverInvert;
					if (maneuverDone) begin
						state       <= ST_DRIVE;
						reverseFlag <= exitReverse;
					end
				end
				default: begin
					state <= ST_DRIVE;
				end
			endcase
		end
	end

endmodule

/* hw/robotDriveTop.sv */
`timescale 1ns/1ps

module robotDriveTop import robotDrivePkg::*; #(
	// 50 MHz clock, 80 Hz PWM
	parameter int unsigned PWM_PERIOD       = 625000,
	parameter int unsigned DUTY_FULL        = 168750,
	parameter int unsigned DUTY_VEER        = 206250,
	parameter int unsigned DUTY_HARD        = 500000,
	parameter int unsigned DUTY_NINETY      = 250000,
	parameter int unsigned DUTY_NINETY_FAST = 262500,
	parameter int unsigned MANEUVER_CYCLES  = 50_000_000
) (
	input  logic       clk,
	input  logic       rst,
	input  steerCmd_t  steer,
	input  logic       obstacle,
	input  toneDir_t   toneDir,
	input  logic       toneReq,
	output motorCmd_t  motor,
	output logic       toneAck,
	output logic [4:0] junctionLeds
);

	speedSet_t speeds;
	steerCmd_t steerSel;
	steerCmd_t maneuverSteer;
	logic      halt;
	logic      invert;
	logic      atJunction;
	logic      maneuverInvert;
	logic      maneuverDone;
	logic      exitReverse;

	////////////////////////////////////////////////////////////
	// Speed sources sharing one period
	////////////////////////////////////////////////////////////

	pwmChannel #(.PWM_PERIOD(PWM_PERIOD), .DUTY(DUTY_FULL)) pwmFull_i (
		.clk   (clk),
		.rst   (rst),
		.level (speeds.full)
	);

	pwmChannel #(.PWM_PERIOD(PWM_PERIOD), .DUTY(DUTY_VEER)) pwmVeer_i (
		.clk   (clk),
		.rst   (rst),
		.level (speeds.veer)
	);

	pwmChannel #(.PWM_PERIOD(PWM_PERIOD), .DUTY(DUTY_HARD)) pwmHard_i (
		.clk   (clk),
		.rst   (rst),
		.level (speeds.hard)
	);

	pwmChannel #(.PWM_PERIOD(PWM_PERIOD), .DUTY(DUTY_NINETY)) pwmNinety_i (
		.clk   (clk),
		.rst   (rst),
		.level (speeds.ninety)
	);

	pwmChannel #(.PWM_PERIOD(PWM_PERIOD), .DUTY(DUTY_NINETY_FAST)) pwmNinetyFast_i (
		.clk   (clk),
		.rst   (rst),
		.level (speeds.ninetyFast)
	);

	////////////////////////////////////////////////////////////
	// Control path
	////////////////////////////////////////////////////////////

	driveController driveController_i (
		.clk            (clk),
		.rst            (rst),
		.steer          (steer),
		.obstacle       (obstacle),
		.maneuverSteer  (maneuverSteer),
		.maneuverInvert (maneuverInvert),
		.maneuverDone   (maneuverDone),
		.exitReverse    (exitReverse),
		.atJunction     (atJunction),
		.steerSel       (steerSel),
		.halt           (halt),
		.invert         (invert)
	);

	junctionSequencer #(.MANEUVER_CYCLES(MANEUVER_CYCLES)) junctionSequencer_i (
		.clk            (clk),
		.rst            (rst),
		.atJunction     (atJunction),
		.toneReq        (toneReq),
		.toneDir        (toneDir),
		.toneAck        (toneAck),
		.maneuverSteer  (maneuverSteer),
		.maneuverInvert (maneuverInvert),
		.maneuverDone   (maneuverDone),
		.exitReverse    (exitReverse),
		.junctionLeds   (junctionLeds)
	);

	steeringDecoder steeringDecoder_i (
		.clk      (clk),
		.rst      (rst),
		.steerSel (steerSel),
		.halt     (halt),
		.invert   (invert),
		.speeds   (speeds),
		.motor    (motor)
	);

endmodule

/* testbench/robotDriveModel.svh */
`ifndef ROBOT_DRIVE_MODEL_SVH
`define ROBOT_DRIVE_MODEL_SVH

// Inner wheel duty by sharpness
function automatic int unsigned innerDuty(sharpness_t s);
	case (s)
		SHARP_VEER:   return DUTY_VEER;
		SHARP_HARD:   return DUTY_VEER;
		SHARP_NINETY: return DUTY_NINETY;
		default:      return DUTY_FULL;
	endcase
endfunction

// Outer wheel duty by sharpness
function automatic int unsigned outerDuty(sharpness_t s);
	case (s)
		SHARP_HARD:   return DUTY_HARD;
		SHARP_NINETY: return DUTY_NINETY_FAST;
		default:      return DUTY_FULL;
	endcase
endfunction

// Side A is the inner wheel on a left turn
function automatic int unsigned dutyA(steerCmd_t c);
	case (c.heading)
		HEAD_PROCEED: return DUTY_FULL;
		HEAD_LEFT:    return innerDuty(c.sharpness);
		HEAD_RIGHT:   return outerDuty(c.sharpness);
		default:      return 0;
	endcase
endfunction

function automatic int unsigned dutyB(steerCmd_t c);
	case (c.heading)
		HEAD_PROCEED: return DUTY_FULL;
		HEAD_LEFT:    return outerDuty(c.sharpness);
		HEAD_RIGHT:   return innerDuty(c.sharpness);
		default:      return 0;
	endcase
endfunction

// Turn pins only for hard and ninety
function automatic logic [3:0] forwardPins(steerCmd_t c);
	logic sharp;
	sharp = (c.sharpness == SHARP_HARD) || (c.sharpness == SHARP_NINETY);
	case (c.heading)
		HEAD_PROCEED: return BRIDGE_STRAIGHT;
		HEAD_LEFT:    return sharp ? BRIDGE_LEFT : BRIDGE_STRAIGHT;
		HEAD_RIGHT:   return sharp ? BRIDGE_RIGHT : BRIDGE_STRAIGHT;
		default:      return BRIDGE_STOP;
	endcase
endfunction

function automatic logic [3:0] reversePins(logic [3:0] p);
	return (p == BRIDGE_STOP) ? BRIDGE_STOP : ~p;
endfunction

// Pins while a junction maneuver runs
function automatic logic [3:0] maneuverPins(toneDir_t d);
	case (d)
		TONE_STRAIGHT: return BRIDGE_STRAIGHT;
		TONE_LEFT:     return BRIDGE_LEFT;
		TONE_RIGHT:    return BRIDGE_RIGHT;
		TONE_BACK:     return reversePins(BRIDGE_STRAIGHT);
		default:       return BRIDGE_STOP;
	endcase
endfunction

function automatic logic [4:0] ledsFor(toneDir_t d);
	case (d)
		TONE_STOP:     return 5'b00001;
		TONE_STRAIGHT: return 5'b00010;
		TONE_LEFT:     return 5'b00100;
		TONE_RIGHT:    return 5'b01000;
		TONE_BACK:     return 5'b10000;
		default:       return 5'b00000;
	endcase
endfunction

`endif

/* testbench/robotDriveTb.sv */
`timescale 1ns/1ps

module robotDriveTb import robotDrivePkg::*; ();

	localparam int unsigned PWM_PERIOD       = 20;
	localparam int unsigned DUTY_FULL        = 5;
	localparam int unsigned DUTY_VEER        = 7;
	localparam int unsigned DUTY_HARD        = 16;
	localparam int unsigned DUTY_NINETY      = 8;
	localparam int unsigned DUTY_NINETY_FAST = 9;
	localparam int unsigned MANEUVER_CYCLES  = 60;

	localparam steerCmd_t STEER_PROCEED = '{heading: HEAD_PROCEED, sharpness: SHARP_FULL};
	localparam steerCmd_t STEER_STOP    = '{heading: HEAD_STOP, sharpness: SHARP_FULL};

	logic       clk;
	logic       rst;
	steerCmd_t  steer;
	logic       obstacle;
	toneDir_t   toneDir;
	logic       toneReq;
	motorCmd_t  motor;
	logic       toneAck;
	logic [4:0] junctionLeds;

	integer seed;
	int     errors;
	int     testCount;
	logic   timedOut;

	`include "robotDriveModel.svh"

	robotDriveTop #(
		.PWM_PERIOD       (PWM_PERIOD),
		.DUTY_FULL        (DUTY_FULL),
		.DUTY_VEER        (DUTY_VEER),
		.DUTY_HARD        (DUTY_HARD),
		.DUTY_NINETY      (DUTY_NINETY),
		.DUTY_NINETY_FAST (DUTY_NINETY_FAST),
		.MANEUVER_CYCLES  (MANEUVER_CYCLES)
	) robotDriveTop_i (
		.clk          (clk),
		.rst          (rst),
		.steer        (steer),
		.obstacle     (obstacle),
		.toneDir      (toneDir),
		.toneReq      (toneReq),
		.motor        (motor),
		.toneAck      (toneAck),
		.junctionLeds (junctionLeds)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic reportMismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testCount++;
		$display("Test %0d %s: %0d errors", testCount, name, errors - startErrors);
	endtask

	// Any heading but stop
	function automatic steerCmd_t randomSteer();
		steerCmd_t c;
		c.heading   = heading_t'(2'({$random(seed)} % 3));
		c.sharpness = sharpness_t'(2'({$random(seed)} % 4));
		return c;
	endfunction

	task automatic waitForAck(input logic level, input int unsigned limit);
		int unsigned n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (toneAck !== level && n < limit);
		if (toneAck !== level) begin
			$display("Timeout: toneAck did not reach %0d within %0d cycles", level, limit);
			timedOut = 1'b1;
			errors++;
		end
	endtask

	task automatic applySteer(input steerCmd_t c);
		@(posedge clk);
		steer <= c;
		repeat (4) @(negedge clk);
	endtask

	task automatic enterJunction();
		applySteer(STEER_STOP);
		if (motor.bridgeIn !== BRIDGE_STOP) begin
			reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(BRIDGE_STOP));
		end
	endtask

	// Full handshake and a timed maneuver, ends when the LEDs clear
	task automatic runJunction(input toneDir_t dir, input steerCmd_t line);
		int unsigned elapsed;
		logic        ackFell;
		@(posedge clk);
		toneDir <= dir;
		toneReq <= 1'b1;
		waitForAck(1'b1, 20);
		if (timedOut) return;
		if (junctionLeds !== ledsFor(dir)) begin
			reportMismatch("junctionLeds", 8'(junctionLeds), 8'(ledsFor(dir)));
		end
		@(posedge clk);
		toneReq <= 1'b0;
		steer   <= line;
		elapsed = 0;
		ackFell = 1'b0;
		do begin
			@(negedge clk);
			elapsed++;
			if (toneAck === 1'b0) ackFell = 1'b1;
			if (junctionLeds != 5'b0 && elapsed >= 2 && motor.bridgeIn !== maneuverPins(dir)) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(maneuverPins(dir)));
			end
		end while (junctionLeds != 5'b0 && elapsed <= MANEUVER_CYCLES + 4);
		if (junctionLeds != 5'b0) begin
			$display("Timeout: maneuver still running after %0d cycles", elapsed);
			timedOut = 1'b1;
			errors++;
		end else if (elapsed < MANEUVER_CYCLES) begin
			$display("Maneuver ended after %0d cycles, short of %0d", elapsed, MANEUVER_CYCLES);
			errors++;
		end
		if (!ackFell) begin
			$display("toneAck never fell after toneReq was dropped");
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic steeringTest();
		steerCmd_t   cmd;
		int unsigned highA;
		int unsigned highB;
		for (int i = 0; i < 40; i++) begin
			cmd = randomSteer();
			applySteer(cmd);
			if (motor.bridgeIn !== forwardPins(cmd)) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(forwardPins(cmd)));
			end
			highA = 0;
			highB = 0;
			repeat (PWM_PERIOD) begin
				@(negedge clk);
				highA += 32'(motor.enA);
				highB += 32'(motor.enB);
			end
			if (highA != dutyA(cmd)) reportMismatch("enA high cycles", 8'(highA), 8'(dutyA(cmd)));
			if (highB != dutyB(cmd)) reportMismatch("enB high cycles", 8'(highB), 8'(dutyB(cmd)));
			// Rest of the two-period hold
			repeat (PWM_PERIOD - 4) @(negedge clk);
		end
	endtask

	task automatic obstacleTest();
		steerCmd_t  cmd;
		steerCmd_t  nextCmd;
		logic [3:0] pins;
		int         delay;
		int         hold;
		for (int i = 0; i < 8; i++) begin
			cmd = randomSteer();
			applySteer(cmd);
			pins    = forwardPins(cmd);
			nextCmd = randomSteer();
			delay   = {$random(seed)} % 10;
			hold    = 4 + {$random(seed)} % 8;
			repeat (delay) @(posedge clk);
			@(posedge clk);
			obstacle <= 1'b1;
			// New line steering must not reach the pins while halted
			steer    <= nextCmd;
			for (int k = 1; k <= hold; k++) begin
				@(negedge clk);
				// Enables off from the second edge after the rise
				if (k >= 3 && (motor.enA !== 1'b0 || motor.enB !== 1'b0)) begin
					reportMismatch("motor enables", 8'({motor.enA, motor.enB}), 8'h00);
				end
				if (motor.bridgeIn !== pins) begin
					reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(pins));
				end
			end
			@(posedge clk);
			obstacle <= 1'b0;
			repeat (4) @(negedge clk);
			if (motor.bridgeIn !== forwardPins(nextCmd)) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(forwardPins(nextCmd)));
			end
		end
	endtask

	task automatic junctionTest();
		toneDir_t  dir;
		steerCmd_t line;
		for (int i = 0; i < 4; i++) begin
			dir  = toneDir_t'(3'({$random(seed)} % 3));
			line = randomSteer();
			enterJunction();
			runJunction(dir, line);
			if (timedOut) return;
			repeat (3) @(negedge clk);
			if (motor.bridgeIn !== forwardPins(line)) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(forwardPins(line)));
			end
		end
	endtask

	task automatic reverseTest();
		steerCmd_t cmd;
		enterJunction();
		runJunction(TONE_BACK, STEER_PROCEED);
		if (timedOut) return;
		repeat (3) @(negedge clk);
		if (motor.bridgeIn !== 4'b1001) reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'h09);
		for (int i = 0; i < 6; i++) begin
			cmd = randomSteer();
			applySteer(cmd);
			if (motor.bridgeIn !== reversePins(forwardPins(cmd))) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn),
					8'(reversePins(forwardPins(cmd))));
			end
		end
		// Straight junction clears reverse
		enterJunction();
		runJunction(TONE_STRAIGHT, STEER_PROCEED);
		if (timedOut) return;
		repeat (3) @(negedge clk);
		if (motor.bridgeIn !== BRIDGE_STRAIGHT) begin
			reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(BRIDGE_STRAIGHT));
		end
	endtask

	task automatic stopTest();
		enterJunction();
		@(posedge clk);
		toneDir <= TONE_STOP;
		toneReq <= 1'b1;
		waitForAck(1'b1, 20);
		if (timedOut) return;
		if (junctionLeds !== ledsFor(TONE_STOP)) begin
			reportMismatch("junctionLeds", 8'(junctionLeds), 8'(ledsFor(TONE_STOP)));
		end
		@(posedge clk);
		toneReq <= 1'b0;
		steer   <= STEER_PROCEED;
		waitForAck(1'b0, 10);
		if (timedOut) return;
		repeat (3 * MANEUVER_CYCLES) begin
			@(negedge clk);
			if (motor.enA !== 1'b0 || motor.enB !== 1'b0) begin
				reportMismatch("motor enables", 8'({motor.enA, motor.enB}), 8'h00);
			end
			if (motor.bridgeIn !== BRIDGE_STOP) begin
				reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'h00);
			end
		end
		runJunction(TONE_STRAIGHT, STEER_PROCEED);
		if (timedOut) return;
		repeat (3) @(negedge clk);
		if (motor.bridgeIn !== BRIDGE_STRAIGHT) begin
			reportMismatch("motor.bridgeIn", 8'(motor.bridgeIn), 8'(BRIDGE_STRAIGHT));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int start;
		seed      = 1;
		errors    = 0;
		testCount = 0;
		timedOut  = 1'b0;
		rst       = 1'b1;
		steer     = STEER_PROCEED;
		obstacle  = 1'b0;
		toneDir   = TONE_STRAIGHT;
		toneReq   = 1'b0;

		start = errors;
		repeat (9) @(posedge clk);
		@(negedge clk);
		if (motor !== '0) reportMismatch("motor", 8'(motor), 8'h00);
		if (toneAck !== 1'b0) reportMismatch("toneAck", 8'(toneAck), 8'h00);
		@(posedge clk);
		rst <= 1'b0;
		steeringTest();
		finishTest("reset and steering duty", start);

		if (!timedOut) begin
			start = errors;
			obstacleTest();
			finishTest("obstacle halt", start);
		end
		if (!timedOut) begin
			start = errors;
			junctionTest();
			finishTest("junction maneuvers", start);
		end
		if (!timedOut) begin
			start = errors;
			reverseTest();
			finishTest("back maneuver and reverse", start);
		end
		if (!timedOut) begin
			start = errors;
			stopTest();
			finishTest("stop command", start);
		end

		$display("%0d tests run, %0d errors", testCount, errors);
		if (errors == 0 && !timedOut) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+testbench
hw/robotDrivePkg.sv
hw/pwmChannel.sv
hw/steeringDecoder.sv
hw/junctionSequencer.sv
hw/driveController.sv
hw/robotDriveTop.sv
testbench/robotDriveTb.sv

/* Makefile */
# Verilator simulation of the robot drive core
VERILATOR ?= verilator
TOP       ?= robotDriveTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
